//--- icache_input.txt
# byte address (hex), expected hit flag (1 hit, 0 miss), L2 delay in cycles
# one fetch per line, run in order
00001040 0 0
00001044 1 0
0000107C 1 0
00001046 1 0
00002040 0 3
00001048 0 5
00002040 0 1
00002050 1 0
12345680 0 20
123456BC 1 0
00000000 0 2
00000010 1 0
FFFFFFC0 0 7
FFFFFFFC 1 0
00000FC4 0 4
FFFFFFC8 0 0
00001040 0 10
00001040 1 0
00002040 0 15
0000207C 1 0
12345684 1 0
ABCDE3C0 0 6
ABCDE3E8 1 0
00000020 1 0
000003C0 0 9
ABCDE3C4 0 12
00000FC4 0 3
00000FF8 1 0
55555540 0 8
5555557F 1 0
55555543 1 0
00000000 1 0
123456A0 1 0
00001040 0 0
00001040 1 0
00000FD0 1 0
12345680 1 0

//--- tb.f
icache_pkg.sv
icache_fetch_in.sv
icache_set_array.sv
icache_refill_ctrl.sv
icache_fetch_out.sv
icache_top.sv
tb_icache.sv

//--- Makefile
TOP = tb_icache
LOG = sim.log

all: run

build:
	verilator --binary --timing -j 0 -f tb.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)
	verilator --lint-only icache_pkg.sv icache_fetch_in.sv icache_set_array.sv \
		icache_refill_ctrl.sv icache_fetch_out.sv icache_top.sv --top-module icache_top

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

//--- tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache
    import icache_pkg::*;
();

    localparam logic [31:0] SEED = 32'd83027;

    logic        clk = 1'b0;
    logic        nrst;
    logic        fetch_req;
    fetch_addr_t fetch_addr;
    logic        busy;
    logic        fetch_valid;
    word_t       fetch_data;
    logic        l2_req;
    line_addr_t  l2_addr;
    logic        l2_valid;
    line_t       l2_line;

    // Sequence read from the input file
    fetch_addr_t addr_q[$];
    logic        hit_q[$];
    int          delay_q[$];
    int          max_delay;

    int          cycle_count = 0;
    int          cycle_limit = 0;

    // L2 model state
    int          l2_delay = 0;
    line_addr_t  l2_seen_addr;
    line_t       l2_buf;

    icache_top uut (
        .clk         (clk),
        .nrst        (nrst),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .busy        (busy),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data),
        .l2_req      (l2_req),
        .l2_addr     (l2_addr),
        .l2_valid    (l2_valid),
        .l2_line     (l2_line)
    );

    initial
    begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Word k of the line that L2 holds at line address la
    function automatic word_t model_word(input line_addr_t la, input int k);
        logic [31:0] state;
        state = SEED ^ 32'(la) ^ (32'(k) << 26);
        state = lcg_next(state);
        state = lcg_next(state);
        return state;
    endfunction

    task automatic stop_with_failure();
        $display("Verification failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_line_addr(input string name, input line_addr_t got,
                                   input line_addr_t exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t: %s = 0x%07h, expected 0x%07h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("ERROR at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic load_sequence();
        int          fd;
        int          n;
        int          h;
        int          d;
        logic [31:0] a;
        string       text;
        fd = $fopen("icache_input.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open icache_input.txt for reading");
            stop_with_failure();
        end
        max_delay = 0;
        while (!$feof(fd))
        begin
            n = $fgets(text, fd);
            // Comment and blank lines do not parse as three fields
            if (n > 0 && $sscanf(text, "%h %d %d", a, h, d) == 3)
            begin
                addr_q.push_back(a);
                hit_q.push_back(h != 0);
                delay_q.push_back(d);
                if (d > max_delay)
                begin
                    max_delay = d;
                end
            end
        end
        $fclose(fd);
        if (addr_q.size() == 0)
        begin
            $display("The input file holds no fetch entries");
            stop_with_failure();
        end
    endtask

    task automatic check_reset_state();
        check_flag("busy", busy, 1'b0);
        check_flag("l2_req", l2_req, 1'b0);
        check_flag("fetch_valid", fetch_valid, 1'b0);
        check_word("fetch_data", fetch_data, '0);
        check_line_addr("l2_addr", l2_addr, '0);
    endtask

    // One fetch from strobe to answer with checks on every falling edge
    task automatic run_fetch(input fetch_addr_t addr, input logic exp_hit, input int delay);
        line_addr_t exp_line;
        word_t      exp_word;
        int         n_edges;
        int         n_l2_req;
        logic       answered;
        exp_line.tag   = addr.tag;
        exp_line.index = addr.index;
        exp_word       = model_word(exp_line, int'(addr.offset[OFFSET_W-1:2]));
        l2_delay       = delay;
        n_edges        = 0;
        n_l2_req       = 0;
        answered       = 1'b0;
        fetch_req  = 1'b1;
        fetch_addr = addr;
        while (!answered)
        begin
            @(negedge clk);
            n_edges++;
            if (n_edges == 1)
            begin
                // A second strobe while busy has to be ignored
                fetch_addr = ~addr;
            end
            else
            begin
                fetch_req  = 1'b0;
                fetch_addr = '0;
            end
            if (l2_req)
            begin
                n_l2_req++;
                check_line_addr("l2_addr", l2_addr, exp_line);
            end
            if (fetch_valid)
            begin
                answered = 1'b1;
                check_flag("busy", busy, 1'b0);
                check_word("fetch_data", fetch_data, exp_word);
            end
            else
            begin
                check_flag("busy", busy, 1'b1);
            end
        end
        check_flag("hit", n_l2_req == 0, exp_hit);
        if (exp_hit)
        begin
            check_cycles("fetch_valid latency", n_edges - 1, 3);
        end
        else
        begin
            check_cycles("l2_req pulses", n_l2_req, 1);
            check_cycles("fetch_valid latency", n_edges - 1, 6 + delay);
        end
        @(negedge clk);
        check_flag("fetch_valid", fetch_valid, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("l2_req", l2_req, 1'b0);
        check_word("fetch_data", fetch_data, exp_word);
    endtask

    // L2 model answering each request after the current entry's delay
    initial
    begin
        l2_valid = 1'b0;
        l2_line  = '0;
        forever
        begin
            @(negedge clk);
            if (l2_req)
            begin
                l2_seen_addr = l2_addr;
                repeat (l2_delay) @(negedge clk);
                for (int k = 0; k < LINE_W / WORD_W; k++)
                begin
                    l2_buf[k*WORD_W +: WORD_W] = model_word(l2_seen_addr, k);
                end
                l2_valid = 1'b1;
                l2_line  = l2_buf;
                @(negedge clk);
                l2_valid = 1'b0;
                l2_line  = '0;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("Timeout: the fetch sequence did not finish in %0d cycles", cycle_limit);
            stop_with_failure();
        end
    end

    initial
    begin
        nrst       = 1'b0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        load_sequence();
        cycle_limit = addr_q.size() * (12 + max_delay) + 50;
        repeat (10) @(negedge clk);
        check_reset_state();
        nrst = 1'b1;
        @(negedge clk);
        check_reset_state();
        for (int i = 0; i < addr_q.size(); i++)
        begin
            run_fetch(addr_q[i], hit_q[i], delay_q[i]);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top
    import icache_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        nrst,

    // Fetch unit
    input  wire logic        fetch_req,
    input  wire fetch_addr_t fetch_addr,
    output logic             busy,
    output logic             fetch_valid,
    output word_t            fetch_data,

    // L2 cache
    output logic             l2_req,
    output line_addr_t       l2_addr,
    input  wire logic        l2_valid,
    input  wire line_t       l2_line
);

    fetch_addr_t req_addr;
    logic        lookup;
    logic        done;
    logic        refill;
    logic        respond;
    tag_entry_t  tag_rd;
    tag_entry_t  tag_wr;
    line_t       line_rd;
    line_t       line_wr;

    icache_fetch_in u_fetch_in (
        .clk        (clk),
        .nrst       (nrst),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .done       (done),
        .req_addr   (req_addr),
        .lookup     (lookup),
        .busy       (busy)
    );

    icache_set_array #(
        .DEPTH_BITS (INDEX_W),
        .entry_t    (tag_entry_t)
    ) u_tags (
        .clk        (clk),
        .nrst       (nrst),
        .index      (req_addr.index),
        .write      (refill),
        .write_data (tag_wr),
        .read_data  (tag_rd)
    );

    icache_set_array #(
        .DEPTH_BITS (INDEX_W),
        .entry_t    (line_t)
    ) u_lines (
        .clk        (clk),
        .nrst       (nrst),
        .index      (req_addr.index),
        .write      (refill),
        .write_data (line_wr),
        .read_data  (line_rd)
    );

    icache_refill_ctrl u_refill_ctrl (
        .clk      (clk),
        .nrst     (nrst),
        .lookup   (lookup),
        .req_addr (req_addr),
        .tag_rd   (tag_rd),
        .l2_valid (l2_valid),
        .l2_line  (l2_line),
        .refill   (refill),
        .tag_wr   (tag_wr),
        .line_wr  (line_wr),
        .l2_req   (l2_req),
        .l2_addr  (l2_addr),
        .respond  (respond),
        .done     (done)
    );

    icache_fetch_out u_fetch_out (
        .clk         (clk),
        .nrst        (nrst),
        .line        (line_rd),
        .offset      (req_addr.offset),
        .respond     (respond),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data)
    );

endmodule

`default_nettype wire

//--- icache_fetch_out.sv
`timescale 1ns/1ps
`default_nettype none

module icache_fetch_out
    import icache_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                nrst,
    input  wire line_t               line,
    input  wire logic [OFFSET_W-1:0] offset,
    input  wire logic                respond,
    output logic                     fetch_valid,
    output word_t                    fetch_data
);

    localparam int SEL_W = OFFSET_W - 2;

    logic [SEL_W-1:0] word_sel;
    word_t            word;

    // Byte bits of the offset do not matter for a word fetch
    assign word_sel = offset[OFFSET_W-1:2];
    assign word     = line[word_sel * WORD_W +: WORD_W];

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            fetch_valid <= 1'b0;
        end
        else
        begin
            fetch_valid <= respond;
        end
    end

    // Data holds between answers
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            fetch_data <= '0;
        end
        else if (respond)
        begin
            fetch_data <= word;
        end
    end

endmodule

`default_nettype wire

//--- icache_refill_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill_ctrl
    import icache_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        nrst,
    input  wire logic        lookup,
    input  wire fetch_addr_t req_addr,
    input  wire tag_entry_t  tag_rd,
    input  wire logic        l2_valid,
    input  wire line_t       l2_line,
    output logic             refill,
    output tag_entry_t       tag_wr,
    output line_t            line_wr,
    output logic             l2_req,
    output line_addr_t       l2_addr,
    output logic             respond,
    output logic             done
);

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_COMPARE,
        S_WAIT_L2,
        S_REREAD,
        S_ANSWER
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   hit;
    logic   miss;

    assign hit  = (state == S_COMPARE) && tag_rd.valid && (tag_rd.tag == req_addr.tag);
    assign miss = (state == S_COMPARE) && !hit;

    always_comb
    begin
        state_nxt = state;
        case (state)
            S_IDLE:    if (lookup) state_nxt = S_COMPARE;
            S_COMPARE: state_nxt = hit ? S_IDLE : S_WAIT_L2;
            S_WAIT_L2: if (l2_valid) state_nxt = S_REREAD;
            // Read register picks up the new entry on this edge
            S_REREAD:  state_nxt = S_ANSWER;
            S_ANSWER:  state_nxt = S_IDLE;
            default:   state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state <= S_IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    // Refill request goes out as a single-cycle pulse
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            l2_req  <= 1'b0;
            l2_addr <= '0;
        end
        else
        begin
            l2_req <= miss;
            if (miss)
            begin
                l2_addr.tag   <= req_addr.tag;
                l2_addr.index <= req_addr.index;
            end
        end
    end

    // Both arrays are written in the cycle the L2 line arrives
    assign refill       = (state == S_WAIT_L2) && l2_valid;
    assign tag_wr.valid = 1'b1;
    assign tag_wr.tag   = req_addr.tag;
    assign line_wr      = l2_line;

    assign respond = hit || (state == S_ANSWER);
    assign done    = respond;

endmodule

`default_nettype wire

//--- icache_set_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_set_array
#(
    parameter int  DEPTH_BITS = 6,
    parameter type entry_t    = logic
)
(
    input  wire logic                  clk,
    input  wire logic                  nrst,
    input  wire logic [DEPTH_BITS-1:0] index,
    input  wire logic                  write,
    input  wire entry_t                write_data,
    output entry_t                     read_data
);

    localparam int DEPTH = 1 << DEPTH_BITS;

    entry_t mem [DEPTH];

    // Storage cleared on reset so every valid bit starts low
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (write)
        begin
            mem[index] <= write_data;
        end
    end

    // Registered read, refreshed every cycle
    // A write shows up here one edge later
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            read_data <= '0;
        end
        else
        begin
            read_data <= mem[index];
        end
    end

endmodule

`default_nettype wire

//--- icache_fetch_in.sv
`timescale 1ns/1ps
`default_nettype none

module icache_fetch_in
    import icache_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        nrst,
    input  wire logic        fetch_req,
    input  wire fetch_addr_t fetch_addr,
    input  wire logic        done,
    output fetch_addr_t      req_addr,
    output logic             lookup,
    output logic             busy
);

    logic accept;
    logic armed;

    // A strobe counts only while no fetch is in flight
    assign accept = fetch_req && !busy;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            req_addr <= '0;
            busy     <= 1'b0;
        end
        else if (accept)
        begin
            req_addr <= fetch_addr;
            busy     <= 1'b1;
        end
        else if (done)
        begin
            busy <= 1'b0;
        end
    end

    // Lookup trails the accepted strobe by one cycle
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            armed  <= 1'b0;
            lookup <= 1'b0;
        end
        else
        begin
            armed  <= accept;
            lookup <= armed;
        end
    end

endmodule

`default_nettype wire

//--- icache_pkg.sv
`default_nettype none

package icache_pkg;

    // Address geometry
    localparam int ADDR_W   = 32;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 6;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // Payload widths
    localparam int LINE_W = 512;
    localparam int WORD_W = 32;

    // Word 0 sits in the lowest bits of the line
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [WORD_W-1:0] word_t;

    // Byte address as seen by the fetch unit
    typedef struct packed
    {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } fetch_addr_t;

    // One entry of the tag array
    typedef struct packed
    {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    // Line address sent to L2, which appends the zero offset itself
    typedef struct packed
    {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
    } line_addr_t;

endpackage

`default_nettype wire
